/* src.f */
hdl/lc_xlate_pkg.sv
hdl/lc_state_sampler.sv
hdl/debug_unlock_decoder.sv
hdl/security_state_fsm.sv
hdl/lc_translator_top.sv
dv/tb_clock_gen.sv
dv/security_state_fsm_properties.sv
dv/lc_translator_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the lifecycle translator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module lc_translator_tb -o lc_translator_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/lc_translator_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Verification passed"; then
  exit 0
else
  exit 1
fi

/* dv/lc_translator_tb.sv */
/*
 * Lifecycle translator testbench
 * Directed tests for reset defaults, lifecycle mapping, debug unlocks,
 * forced lock, volatile RAW unlock and SoC enable decoding
 */
`timescale 1ns/1ps

module lc_translator_tb;
  import lc_xlate_pkg::*;

  localparam int unsigned DBG_LEVEL_W = 64;
  localparam int          WAIT_LIMIT  = 20;
  // Any pattern other than LC_TX_ON counts as off
  localparam lc_tx_t      TX_OFF      = 4'b1010;

  logic                   clk;
  logic                   rst_n;
  otp_lc_data_t           otp_data;
  lc_prog_req_t           lc_prog_req;
  logic                   volatile_raw_unlock;
  lc_tx_t                 lc_dft_en;
  lc_tx_t                 lc_hw_debug_en;
  logic                   state_error;
  logic                   early_warm_reset_warn;
  logic                   dbg_manuf_enable;
  logic [DBG_LEVEL_W-1:0] dbg_unlock_level;
  logic [DBG_LEVEL_W-1:0] dft_en_mask;
  logic [DBG_LEVEL_W-1:0] dbg_unlock_mask;
  logic [DBG_LEVEL_W-1:0] cltap_unlock_mask;
  logic                   soc_dft_en;
  logic                   soc_hw_debug_en;
  lc_state_e              otp_static_state;
  security_state_t        security_state;
  integer                 seed;

  tb_clock_gen #(.PERIOD_NS(8.0)) tb_clock_gen_inst (.clk_o(clk));

  lc_translator_top #(
    .DBG_LEVEL_W (DBG_LEVEL_W)
  ) lc_translator_top_inst (
    .clk_i                   (clk),
    .rst_ni                  (rst_n),
    .otp_data_i              (otp_data),
    .lc_prog_req_i           (lc_prog_req),
    .volatile_raw_unlock_i   (volatile_raw_unlock),
    .lc_dft_en_i             (lc_dft_en),
    .lc_hw_debug_en_i        (lc_hw_debug_en),
    .state_error_i           (state_error),
    .early_warm_reset_warn_i (early_warm_reset_warn),
    .dbg_manuf_enable_i      (dbg_manuf_enable),
    .dbg_unlock_level_i      (dbg_unlock_level),
    .dft_en_mask_i           (dft_en_mask),
    .dbg_unlock_mask_i       (dbg_unlock_mask),
    .cltap_unlock_mask_i     (cltap_unlock_mask),
    .soc_dft_en_o            (soc_dft_en),
    .soc_hw_debug_en_o       (soc_hw_debug_en),
    .otp_static_state_o      (otp_static_state),
    .security_state_o        (security_state)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic security_state_t sec(input lifecycle_e lc, input logic locked);
    security_state_t s;
    s.device_lifecycle = lc;
    s.debug_locked     = locked;
    return s;
  endfunction

  // Security value of the IDLE branch with no unlock and no lock request
  function automatic security_state_t mapped_security(input lc_state_e st);
    if (st >= LC_ST_TEST_UNLOCKED0 && st <= LC_ST_TEST_UNLOCKED7) begin
      return sec(DEVICE_UNPROVISIONED, 1'b0);
    end
    if (st == LC_ST_DEV) return sec(DEVICE_MANUFACTURING, 1'b1);
    if (st == LC_ST_RMA) return sec(DEVICE_PRODUCTION, 1'b0);
    // RAW, TEST_LOCKED, PROD, PROD_END, SCRAP and INVALID all stay locked
    return SECURITY_DEFAULT;
  endfunction

  // Enable is the lifecycle ON value or any masked level bit unless a scrap is pending
  function automatic logic expected_enable(input lc_tx_t lc_en,
                                           input logic [DBG_LEVEL_W-1:0] level,
                                           input logic [DBG_LEVEL_W-1:0] mask,
                                           input logic manuf_term,
                                           input logic scrap);
    return ((lc_en == LC_TX_ON) || (|(level & mask)) || manuf_term) && !scrap;
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_security(input string name, input security_state_t got,
                                input security_state_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_enable(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_lc_state(input string name, input lc_state_e got, input lc_state_e exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_defaults();
    check_security("security_state_o", security_state, SECURITY_DEFAULT);
    check_enable("soc_dft_en_o", soc_dft_en, 1'b0);
    check_enable("soc_hw_debug_en_o", soc_hw_debug_en, 1'b0);
    check_lc_state("otp_static_state_o", otp_static_state, LC_ST_RAW);
  endtask

  // --------------------------------------------------
  // Stimulus helpers called on a falling edge
  // --------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_security(input security_state_t exp);
    int cycles;
    cycles = 0;
    while (security_state !== exp && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (security_state !== exp) begin
      report_failure($sformatf("Timed out after %0d cycles waiting for security state 0x%0h",
                               WAIT_LIMIT, exp));
    end
  endtask

  // Two cycles without valid bring every register back to its reset value
  task automatic restart_translation();
    otp_data              = '0;
    lc_prog_req           = '0;
    volatile_raw_unlock   = 1'b0;
    lc_dft_en             = TX_OFF;
    lc_hw_debug_en        = TX_OFF;
    state_error           = 1'b0;
    early_warm_reset_warn = 1'b0;
    dbg_manuf_enable      = 1'b0;
    dbg_unlock_level      = '0;
    dft_en_mask           = '0;
    dbg_unlock_mask       = '0;
    cltap_unlock_mask     = '0;
    wait_cycles(2);
  endtask

  task automatic start_lifecycle(input lc_state_e st);
    otp_data.state = st;
    otp_data.valid = 1'b1;
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  // Nothing may leak through while the fuse data is not valid
  task automatic hold_invalid_defaults();
    restart_translation();
    otp_data.state = LC_ST_RMA;
    lc_dft_en      = LC_TX_ON;
    lc_hw_debug_en = LC_TX_ON;
    wait_cycles(3);
    check_defaults();
  endtask

  // Edge one reaches IDLE, edge two the branch, edge three the output
  task automatic map_each_lifecycle();
    lc_state_e st;
    for (int i = 0; i <= int'(LC_ST_INVALID); i++) begin
      st = lc_state_e'(i[4:0]);
      restart_translation();
      start_lifecycle(st);
      wait_cycles(3);
      check_lc_state("otp_static_state_o", otp_static_state, st);
      check_security("security_state_o", security_state, mapped_security(st));
    end
  endtask

  task automatic unlock_debug();
    logic [DBG_LEVEL_W-1:0] level;
    logic [DBG_LEVEL_W-1:0] mask;
    restart_translation();
    dbg_manuf_enable = 1'b1;
    start_lifecycle(LC_ST_DEV);
    wait_security(sec(DEVICE_MANUFACTURING, 1'b0));
    level = {$random(seed), $random(seed)};
    mask  = {$random(seed), $random(seed)};
    if ((level & mask) == '0) begin
      level[0] = 1'b1;
      mask[0]  = 1'b1;
    end
    restart_translation();
    dbg_unlock_level = level;
    dbg_unlock_mask  = mask;
    start_lifecycle(LC_ST_PROD);
    wait_security(sec(DEVICE_PRODUCTION, 1'b0));
    // A mask that misses every level bit keeps production locked
    restart_translation();
    dbg_unlock_level = level;
    dbg_unlock_mask  = ~level;
    start_lifecycle(LC_ST_PROD);
    repeat (6) begin
      @(negedge clk);
      check_security("security_state_o", security_state, SECURITY_DEFAULT);
    end
  endtask

  task automatic force_lock();
    restart_translation();
    start_lifecycle(LC_ST_RMA);
    wait_security(sec(DEVICE_PRODUCTION, 1'b0));
    state_error = 1'b1;
    wait_cycles(1);
    check_security("security_state_o", security_state, SECURITY_DEFAULT);
    // Once in NON_DEBUG the error going away does not reopen debug
    state_error = 1'b0;
    wait_cycles(2);
    check_security("security_state_o", security_state, SECURITY_DEFAULT);
    restart_translation();
    volatile_raw_unlock = 1'b1;
    start_lifecycle(LC_ST_RAW);
    wait_security(sec(DEVICE_UNPROVISIONED, 1'b0));
    early_warm_reset_warn = 1'b1;
    wait_cycles(1);
    check_security("security_state_o", security_state, SECURITY_DEFAULT);
    early_warm_reset_warn = 1'b0;
    wait_security(sec(DEVICE_UNPROVISIONED, 1'b0));
  endtask

  task automatic decode_enables();
    int   r;
    logic exp_dft;
    logic exp_hw;
    restart_translation();
    start_lifecycle(LC_ST_PROD);
    for (int t = 0; t < 24; t++) begin
      r = $random(seed);
      // One-hot levels mix hits and misses and a zero level isolates mask bit 0
      dbg_unlock_level  = (t % 4 == 0) ? '0 : (64'd1 << r[5:0]);
      dft_en_mask       = {$random(seed), $random(seed)};
      cltap_unlock_mask = {$random(seed), $random(seed)};
      dbg_manuf_enable  = r[6];
      lc_dft_en         = r[7] ? LC_TX_ON : r[11:8];
      lc_hw_debug_en    = r[12] ? LC_TX_ON : r[16:13];
      exp_dft = expected_enable(lc_dft_en, dbg_unlock_level, dft_en_mask,
                                dbg_manuf_enable && dft_en_mask[0], 1'b0);
      exp_hw  = expected_enable(lc_hw_debug_en, dbg_unlock_level, cltap_unlock_mask,
                                1'b0, 1'b0);
      wait_cycles(1);
      check_enable("soc_dft_en_o", soc_dft_en, exp_dft);
      check_enable("soc_hw_debug_en_o", soc_hw_debug_en, exp_hw);
    end
    // Scrap wins even with every enable source and the production unlock active
    lc_dft_en         = LC_TX_ON;
    lc_hw_debug_en    = LC_TX_ON;
    dbg_unlock_level  = '1;
    dft_en_mask       = '1;
    cltap_unlock_mask = '1;
    dbg_unlock_mask   = '1;
    lc_prog_req.req   = 1'b1;
    lc_prog_req.state = LC_ST_SCRAP;
    wait_cycles(1);
    check_enable("soc_dft_en_o", soc_dft_en, 1'b0);
    check_enable("soc_hw_debug_en_o", soc_hw_debug_en, 1'b0);
    lc_prog_req = '0;
    wait_cycles(1);
    check_enable("soc_dft_en_o", soc_dft_en, 1'b1);
    check_enable("soc_hw_debug_en_o", soc_hw_debug_en, 1'b1);
    // Scrap parked the FSM in NON_DEBUG where the production unlock has no effect
    check_security("security_state_o", security_state, SECURITY_DEFAULT);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    seed  = 1575;
    rst_n = 1'b0;
    otp_data              = '0;
    lc_prog_req           = '0;
    volatile_raw_unlock   = 1'b0;
    lc_dft_en             = TX_OFF;
    lc_hw_debug_en        = TX_OFF;
    state_error           = 1'b0;
    early_warm_reset_warn = 1'b0;
    dbg_manuf_enable      = 1'b0;
    dbg_unlock_level      = '0;
    dft_en_mask           = '0;
    dbg_unlock_mask       = '0;
    cltap_unlock_mask     = '0;
    wait_cycles(5);
    check_defaults();
    rst_n = 1'b1;
    hold_invalid_defaults();
    map_each_lifecycle();
    unlock_debug();
    force_lock();
    decode_enables();
    $display("Verification passed");
    $finish;
  end

endmodule

/* dv/security_state_fsm_properties.sv */
/*
 * Security state FSM properties
 * Invalid fuse data, lock requests in a branch state and the warm reset
 * warning must all leave a locked security state on the next edge
 */
`timescale 1ns/1ps

module security_state_fsm_properties (
  input logic                          clk_i,
  input logic                          rst_ni,
  input lc_xlate_pkg::lc_view_t        lc_view_i,
  input logic                          early_warm_reset_warn_i,
  input lc_xlate_pkg::xlate_state_e    state_i,
  input lc_xlate_pkg::security_state_t security_state_i
);
  import lc_xlate_pkg::*;

  logic in_branch;

  // RESET and IDLE are the only states outside the lifecycle branches
  assign in_branch = (state_i != XLATE_RESET) && (state_i != XLATE_IDLE);

  // Dropping valid restarts the FSM and parks the output on the default
  invalid_gives_default_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !lc_view_i.valid |=> (security_state_i == SECURITY_DEFAULT)
  ) else $error("Security state not default after invalid fuse data");

  // A lock request must never leave debug open for even one cycle
  lock_gives_locked_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lc_view_i.valid && lc_view_i.lock_req && in_branch) |=> security_state_i.debug_locked
  ) else $error("Debug still open after a lock request");

  // The warm reset warning overrides whatever the state maps to
  warm_reset_gives_default_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lc_view_i.valid && early_warm_reset_warn_i) |=> (security_state_i == SECURITY_DEFAULT)
  ) else $error("Security state not default after warm reset warning");

endmodule

bind security_state_fsm security_state_fsm_properties security_state_fsm_properties_inst (
  .clk_i                   (clk_i),
  .rst_ni                  (rst_ni),
  .lc_view_i               (lc_view_i),
  .early_warm_reset_warn_i (early_warm_reset_warn_i),
  .state_i                 (state_q),
  .security_state_i        (security_state_o)
);

/* dv/tb_clock_gen.sv */
/*
 * Testbench clock generator
 * Free running clock, 8 ns period by default
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);
  // Starts low so the first event is a rising edge
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end
endmodule

/* hdl/lc_translator_top.sv */
/*
 * Lifecycle to security state translator top
 * Connects the lifecycle sampler, the debug unlock decoder and the
 * security state FSM
 */
`timescale 1ns/1ps

module lc_translator_top #(
  parameter int unsigned DBG_LEVEL_W = lc_xlate_pkg::DEFAULT_DBG_LEVEL_W
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Fuse controller and lifecycle controller
  input  lc_xlate_pkg::otp_lc_data_t    otp_data_i,
  input  lc_xlate_pkg::lc_prog_req_t    lc_prog_req_i,
  input  logic                          volatile_raw_unlock_i,
  input  lc_xlate_pkg::lc_tx_t          lc_dft_en_i,
  input  lc_xlate_pkg::lc_tx_t          lc_hw_debug_en_i,
  // System level controls
  input  logic                          state_error_i,
  input  logic                          early_warm_reset_warn_i,
  // Debug unlock request and the SoC masks
  input  logic                          dbg_manuf_enable_i,
  input  logic [DBG_LEVEL_W-1:0]        dbg_unlock_level_i,
  input  logic [DBG_LEVEL_W-1:0]        dft_en_mask_i,
  input  logic [DBG_LEVEL_W-1:0]        dbg_unlock_mask_i,
  input  logic [DBG_LEVEL_W-1:0]        cltap_unlock_mask_i,
  output logic                          soc_dft_en_o,
  output logic                          soc_hw_debug_en_o,
  output lc_xlate_pkg::lc_state_e       otp_static_state_o,
  output lc_xlate_pkg::security_state_t security_state_o
);
  import lc_xlate_pkg::*;

  lc_view_t lc_view;
  logic     prod_unlock;

  // The registered lifecycle state is also exported to the SoC
  assign otp_static_state_o = lc_view.static_state;

  lc_state_sampler lc_state_sampler_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .otp_data_i    (otp_data_i),
    .lc_prog_req_i (lc_prog_req_i),
    .state_error_i (state_error_i),
    .lc_view_o     (lc_view)
  );

  debug_unlock_decoder #(
    .DBG_LEVEL_W (DBG_LEVEL_W)
  ) debug_unlock_decoder_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .lc_view_i           (lc_view),
    .lc_dft_en_i         (lc_dft_en_i),
    .lc_hw_debug_en_i    (lc_hw_debug_en_i),
    .dbg_manuf_enable_i  (dbg_manuf_enable_i),
    .dbg_unlock_level_i  (dbg_unlock_level_i),
    .dft_en_mask_i       (dft_en_mask_i),
    .dbg_unlock_mask_i   (dbg_unlock_mask_i),
    .cltap_unlock_mask_i (cltap_unlock_mask_i),
    .prod_unlock_o       (prod_unlock),
    .soc_dft_en_o        (soc_dft_en_o),
    .soc_hw_debug_en_o   (soc_hw_debug_en_o)
  );

  security_state_fsm security_state_fsm_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .lc_view_i               (lc_view),
    .volatile_raw_unlock_i   (volatile_raw_unlock_i),
    .dbg_manuf_enable_i      (dbg_manuf_enable_i),
    .prod_unlock_i           (prod_unlock),
    .early_warm_reset_warn_i (early_warm_reset_warn_i),
    .security_state_o        (security_state_o)
  );

endmodule

/* hdl/security_state_fsm.sv */
/*
 * Security state translator FSM
 * Maps the sampled lifecycle state to a device lifecycle and debug lock,
 * honors manufacturing, production and volatile RAW unlocks, and falls
 * back to locked production on any lock request or warm reset warning
 */
`timescale 1ns/1ps

module security_state_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  lc_xlate_pkg::lc_view_t        lc_view_i,
  input  logic                          volatile_raw_unlock_i,
  input  logic                          dbg_manuf_enable_i,
  input  logic                          prod_unlock_i,
  input  logic                          early_warm_reset_warn_i,
  output lc_xlate_pkg::security_state_t security_state_o
);
  import lc_xlate_pkg::*;

  xlate_state_e    state_q;
  xlate_state_e    state_d;
  security_state_t security_d;

  // --------------------------------------------------
  // State and output registers
  // --------------------------------------------------
  // Nothing advances unless the fuse data is valid
  // Invalid data restarts the translation from RESET
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= XLATE_RESET;
      security_state_o <= SECURITY_DEFAULT;
    end else if (lc_view_i.valid) begin
      state_q          <= state_d;
      security_state_o <= early_warm_reset_warn_i ? SECURITY_DEFAULT : security_d;
    end else begin
      state_q          <= XLATE_RESET;
      security_state_o <= SECURITY_DEFAULT;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      XLATE_RESET: begin
        state_d = XLATE_IDLE;
      end
      XLATE_IDLE: begin
        // Scrap and state errors win over whatever the fuses report
        if (lc_view_i.lock_req || (lc_view_i.static_state == LC_ST_SCRAP)) begin
          state_d = XLATE_NON_DEBUG;
        end else begin
          case (lc_view_i.static_state) inside
            LC_ST_RAW, [LC_ST_TEST_LOCKED0:LC_ST_TEST_LOCKED6]: state_d = XLATE_NON_DEBUG;
            [LC_ST_TEST_UNLOCKED0:LC_ST_TEST_UNLOCKED7]:        state_d = XLATE_UNPROV_DEBUG;
            LC_ST_DEV:                                          state_d = XLATE_MANUF_NON_DEBUG;
            LC_ST_PROD, LC_ST_PROD_END:                         state_d = XLATE_PROD_NON_DEBUG;
            LC_ST_RMA:                                          state_d = XLATE_PROD_DEBUG;
            // INVALID keeps waiting in IDLE
            default:                                            state_d = XLATE_IDLE;
          endcase
        end
      end
      XLATE_NON_DEBUG: begin
        // A volatile RAW unlock only counts while nothing asks for a lock
        if (volatile_raw_unlock_i && !lc_view_i.lock_req) begin
          state_d = XLATE_UNPROV_DEBUG;
        end
      end
      XLATE_MANUF_NON_DEBUG: begin
        if (lc_view_i.lock_req) begin
          state_d = XLATE_NON_DEBUG;
        end else if (dbg_manuf_enable_i) begin
          state_d = XLATE_MANUF_DEBUG;
        end
      end
      XLATE_PROD_NON_DEBUG: begin
        if (lc_view_i.lock_req) begin
          state_d = XLATE_NON_DEBUG;
        end else if (prod_unlock_i) begin
          state_d = XLATE_PROD_DEBUG;
        end
      end
      // The debug states only ever leave towards NON_DEBUG
      default: begin
        if (lc_view_i.lock_req) begin
          state_d = XLATE_NON_DEBUG;
        end
      end
    endcase
  end

  // --------------------------------------------------
  // Security value of the current state
  // --------------------------------------------------
  // A lock request drops to the default right away, one edge ahead of the state
  always_comb begin
    security_d = SECURITY_DEFAULT;
    if (!lc_view_i.lock_req) begin
      case (state_q)
        XLATE_UNPROV_DEBUG:    security_d = '{DEVICE_UNPROVISIONED, 1'b0};
        XLATE_MANUF_NON_DEBUG: security_d = '{DEVICE_MANUFACTURING, 1'b1};
        XLATE_MANUF_DEBUG:     security_d = '{DEVICE_MANUFACTURING, 1'b0};
        XLATE_PROD_DEBUG:      security_d = '{DEVICE_PRODUCTION, 1'b0};
        default:               security_d = SECURITY_DEFAULT;
      endcase
    end
  end

endmodule

/* hdl/debug_unlock_decoder.sv */
/*
 * Debug unlock decoder
 * Reduces the masked debug unlock level into the DFT, hardware debug and
 * production unlock terms, and registers the SoC DFT and debug enables
 */
`timescale 1ns/1ps

module debug_unlock_decoder #(
  parameter int unsigned DBG_LEVEL_W = lc_xlate_pkg::DEFAULT_DBG_LEVEL_W
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lc_xlate_pkg::lc_view_t lc_view_i,
  input  lc_xlate_pkg::lc_tx_t   lc_dft_en_i,
  input  lc_xlate_pkg::lc_tx_t   lc_hw_debug_en_i,
  input  logic                   dbg_manuf_enable_i,
  input  logic [DBG_LEVEL_W-1:0] dbg_unlock_level_i,
  input  logic [DBG_LEVEL_W-1:0] dft_en_mask_i,
  input  logic [DBG_LEVEL_W-1:0] dbg_unlock_mask_i,
  input  logic [DBG_LEVEL_W-1:0] cltap_unlock_mask_i,
  output logic                   prod_unlock_o,
  output logic                   soc_dft_en_o,
  output logic                   soc_hw_debug_en_o
);
  import lc_xlate_pkg::*;

  logic dft_unlock;
  logic hw_unlock;

  // --------------------------------------------------
  // Masked level reduction
  // --------------------------------------------------
  // Manufacturing debug has a single level, so it only looks at mask bit 0
  assign dft_unlock = (|(dbg_unlock_level_i & dft_en_mask_i)) ||
                      (dbg_manuf_enable_i && dft_en_mask_i[0]);

  // The CLTAP mask selects which levels open hardware debug
  assign hw_unlock = |(dbg_unlock_level_i & cltap_unlock_mask_i);

  // Production unlock goes to the FSM rather than to an enable pin
  assign prod_unlock_o = |(dbg_unlock_level_i & dbg_unlock_mask_i);

  // --------------------------------------------------
  // Registered SoC enables
  // --------------------------------------------------
  // The lifecycle controller enable or the unlock term turns an enable on
  // A pending scrap overrides both, and invalid fuse data clears them
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (lc_view_i.valid) begin
      soc_dft_en_o      <= ((lc_dft_en_i == LC_TX_ON) || dft_unlock) &&
                           !lc_view_i.scrap_req;
      soc_hw_debug_en_o <= ((lc_hw_debug_en_i == LC_TX_ON) || hw_unlock) &&
                           !lc_view_i.scrap_req;
    end else begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

/* hdl/lc_state_sampler.sv */
/*
 * Lifecycle state sampler
 * Holds the lifecycle state reported by the fuse controller while its data
 * is valid and derives the scrap and lock requests for the translator
 */
`timescale 1ns/1ps

module lc_state_sampler (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  lc_xlate_pkg::otp_lc_data_t otp_data_i,
  input  lc_xlate_pkg::lc_prog_req_t lc_prog_req_i,
  input  logic                       state_error_i,
  output lc_xlate_pkg::lc_view_t     lc_view_o
);
  import lc_xlate_pkg::*;

  lc_state_e static_state_q;
  logic      scrap_req;
  logic      lock_req;

  // --------------------------------------------------
  // Static lifecycle register
  // --------------------------------------------------
  // The state is only trusted while the fuse data is valid
  // Dropping valid brings it straight back to RAW on the next edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      static_state_q <= LC_ST_RAW;
    end else if (otp_data_i.valid) begin
      static_state_q <= otp_data_i.state;
    end else begin
      static_state_q <= LC_ST_RAW;
    end
  end

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------
  // A program request that targets SCRAP is taken as a scrap request
  assign scrap_req = lc_prog_req_i.req && (lc_prog_req_i.state == LC_ST_SCRAP);

  // Either a scrap or a reported state error locks the device down
  assign lock_req = scrap_req || state_error_i;

  // Requests stay combinational so the FSM can react on the same edge
  assign lc_view_o = '{
    valid:        otp_data_i.valid,
    static_state: static_state_q,
    scrap_req:    scrap_req,
    lock_req:     lock_req
  };

endmodule

/* hdl/lc_xlate_pkg.sv */
/*
 * Lifecycle translator package
 * Compact lifecycle state encoding, multibit enable values, the security
 * state struct, the fuse and program request structs, the internal view
 * shared between the sampler, the decoder and the translator FSM
 */
package lc_xlate_pkg;

  // Default width of the debug unlock level and its masks
  parameter int unsigned DEFAULT_DBG_LEVEL_W = 64;

  // --------------------------------------------------
  // Lifecycle states as reported by the fuse controller
  // --------------------------------------------------
  // RAW must stay at zero since cleared registers read as RAW
  typedef enum logic [4:0] {
    LC_ST_RAW = 5'd0,
    LC_ST_TEST_UNLOCKED0, LC_ST_TEST_UNLOCKED1, LC_ST_TEST_UNLOCKED2, LC_ST_TEST_UNLOCKED3,
    LC_ST_TEST_UNLOCKED4, LC_ST_TEST_UNLOCKED5, LC_ST_TEST_UNLOCKED6, LC_ST_TEST_UNLOCKED7,
    LC_ST_TEST_LOCKED0, LC_ST_TEST_LOCKED1, LC_ST_TEST_LOCKED2, LC_ST_TEST_LOCKED3,
    LC_ST_TEST_LOCKED4, LC_ST_TEST_LOCKED5, LC_ST_TEST_LOCKED6,
    LC_ST_DEV, LC_ST_PROD, LC_ST_PROD_END, LC_ST_RMA, LC_ST_SCRAP, LC_ST_INVALID
  } lc_state_e;

  // Multibit enable from the lifecycle controller
  // Only the exact ON pattern enables, every other value is treated as off
  typedef logic [3:0] lc_tx_t;
  parameter lc_tx_t LC_TX_ON = 4'b0101;

  // --------------------------------------------------
  // Security state driven towards the core
  // --------------------------------------------------
  typedef enum logic [1:0] {
    DEVICE_UNPROVISIONED = 2'b00,
    DEVICE_MANUFACTURING = 2'b01,
    DEVICE_PRODUCTION    = 2'b11
  } lifecycle_e;

  typedef struct packed {
    lifecycle_e device_lifecycle;
    logic       debug_locked;
  } security_state_t;

  // Locked production is the safe fallback for every error path
  parameter security_state_t SECURITY_DEFAULT = '{
    device_lifecycle: DEVICE_PRODUCTION,
    debug_locked:     1'b1
  };

  // --------------------------------------------------
  // Interface structs
  // --------------------------------------------------
  // Fuse controller data, valid is a level qualifier
  typedef struct packed {
    logic      valid;
    lc_state_e state;
  } otp_lc_data_t;

  // Program request from the lifecycle controller to the fuses
  typedef struct packed {
    logic      req;
    lc_state_e state;
  } lc_prog_req_t;

  // Sampled view of the lifecycle seen by the FSM and the enable decoder
  typedef struct packed {
    logic      valid;
    lc_state_e static_state;
    logic      scrap_req;
    logic      lock_req;
  } lc_view_t;

  // Translator FSM states
  typedef enum logic [2:0] {
    XLATE_RESET, XLATE_IDLE, XLATE_NON_DEBUG, XLATE_UNPROV_DEBUG,
    XLATE_MANUF_NON_DEBUG, XLATE_MANUF_DEBUG, XLATE_PROD_NON_DEBUG, XLATE_PROD_DEBUG
  } xlate_state_e;

endpackage
